/* imem_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// instruction memory side definitions
// byte addresses, 128-bit memory lines and the split of an address into
// line number and word select
////////////////////////////////////////////////////////////////////////////

package imem_pkg;

  // basic widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;

  // four 32-bit words per memory line
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned LINE_W = LINE_WORDS * WORD_W;

  // word select sits right above the byte offset
  localparam int unsigned WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int unsigned LINE_OFFS_W = WORD_SEL_W + 2;
  localparam int unsigned LINE_ADDR_W = ADDR_W - LINE_OFFS_W;

  // byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // one full memory line, word 0 in the low bits
  typedef logic [LINE_W-1:0] line_t;

  // upper address bits, one value per line
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // word index inside a line
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

endpackage

/* fetch_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// core side fetch definitions
// instruction word, hardware loop counter and the FSM encodings
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  localparam int unsigned INSTR_W = 32;
  localparam int unsigned LOOP_CNT_W = 16;

  // one uncompressed instruction
  typedef logic [INSTR_W-1:0] instr_t;

  // hardware loop iteration count
  typedef logic [LOOP_CNT_W-1:0] loop_cnt_t;

  // L0 buffer FSM
  typedef enum logic [2:0] {
    EMPTY,
    WAIT_GNT,
    WAIT_RVALID,
    VALID_L0,
    ABORTED_BRANCH
  } l0_state_e;

  // sequencer waits for the first redirect
  typedef enum logic {
    IDLE,
    RUN
  } seq_state_e;

endpackage

/* l0_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// L0 line buffer
// runs the req/gnt/rvalid handshake towards instruction memory and keeps
// the last line it received, one request outstanding at most
// returned data is forwarded to the aligner in the rvalid cycle
////////////////////////////////////////////////////////////////////////////

module l0_buffer (
  input  logic                 clk,
  input  logic                 rst_n,

  // request pulses from the sequencer
  input  logic                 prefetch_i,
  input  imem_pkg::addr_t      prefetch_addr_i,
  input  logic                 branch_i,
  input  imem_pkg::addr_t      branch_addr_i,
  input  logic                 hwlp_i,
  input  imem_pkg::addr_t      hwlp_addr_i,

  // instruction memory
  output logic                 imem_req_o,
  output imem_pkg::addr_t      imem_addr_o,
  input  logic                 imem_gnt_i,
  input  logic                 imem_rvalid_i,
  input  imem_pkg::line_t      imem_rdata_i,

  // line towards the aligner
  output logic                 line_valid_o,
  output imem_pkg::line_t      line_data_o,
  output imem_pkg::line_addr_t line_addr_o,

  output logic                 busy_o
);

  import imem_pkg::*;
  import fetch_pkg::*;

  l0_state_e  state_q;
  l0_state_e  state_d;

  line_t      line_q;
  line_addr_t addr_q;
  addr_t      addr_int;
  addr_t      req_addr;
  logic       any_req;
  logic       valid;

  // any new request this cycle
  assign any_req = branch_i | hwlp_i | prefetch_i;

  // branch beats loop jump, loop jump beats prefetch
  always_comb
  begin
    if (branch_i)
      req_addr = branch_addr_i;
    else if (hwlp_i)
      req_addr = hwlp_addr_i;
    else
      req_addr = prefetch_addr_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    valid      = 1'b0;
    imem_req_o = 1'b0;
    // default keeps the pending line address
    addr_int   = {addr_q, {LINE_OFFS_W{1'b0}}};

    case (state_q)
      // nothing fetched yet
      EMPTY:
      begin
        addr_int = req_addr;
        if (any_req)
        begin
          imem_req_o = 1'b1;
          state_d    = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request held until memory takes it
      WAIT_GNT:
      begin
        imem_req_o = 1'b1;
        // only a redirect may swap the address
        if (branch_i)
          addr_int = branch_addr_i;
        state_d = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
      end

      WAIT_RVALID:
      begin
        valid    = imem_rvalid_i;
        addr_int = req_addr;
        if (branch_i)
        begin
          // redirect with data arriving now, drop it and go again
          if (imem_rvalid_i)
          begin
            imem_req_o = 1'b1;
            state_d    = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
          else
          begin
            state_d = ABORTED_BRANCH;
          end
        end
        else if (imem_rvalid_i)
        begin
          if (prefetch_i | hwlp_i)
          begin
            imem_req_o = 1'b1;
            state_d    = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
          else
          begin
            state_d = VALID_L0;
          end
        end
      end

      // line register holds good data
      VALID_L0:
      begin
        valid    = 1'b1;
        addr_int = req_addr;
        if (any_req)
        begin
          imem_req_o = 1'b1;
          state_d    = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // stale response still in flight
      ABORTED_BRANCH:
      begin
        // address ready early so it does not depend on rvalid
        if (branch_i)
          addr_int = branch_addr_i;
        if (imem_rvalid_i)
        begin
          imem_req_o = 1'b1;
          state_d    = imem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default:
      begin
        state_d = EMPTY;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= EMPTY;
    else
      state_q <= state_d;
  end

  // line number of the latest request
  always_ff @(posedge clk)
  begin
    if (any_req)
      addr_q <= addr_int[ADDR_W-1:LINE_OFFS_W];
  end

  // only a live response is kept, aborted data is never stored
  always_ff @(posedge clk)
  begin
    if (imem_rvalid_i && (state_q == WAIT_RVALID))
      line_q <= imem_rdata_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////////

  // memory sees line aligned addresses only
  assign imem_addr_o = {addr_int[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};

  // bypass in the rvalid cycle
  assign line_data_o = imem_rvalid_i ? imem_rdata_i : line_q;
  assign line_addr_o = addr_q;

  // a request pulse means the pc left this line
  // so the old line must not feed the aligner
  assign line_valid_o = valid & ~any_req;

  // idle only when empty or holding a line with no request
  assign busy_o = ((state_q != EMPTY) && (state_q != VALID_L0)) || imem_req_o;

endmodule

/* fetch_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// fetch sequencer
// keeps the program counter, runs one hardware loop and turns pc moves
// into registered prefetch, branch and loop jump pulses for the L0 buffer
////////////////////////////////////////////////////////////////////////////

module fetch_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,

  // redirect from the core
  input  logic                 branch_i,
  input  imem_pkg::addr_t      branch_addr_i,

  // hardware loop setup
  input  logic                 hwlp_set_i,
  input  imem_pkg::addr_t      hwlp_start_i,
  input  imem_pkg::addr_t      hwlp_end_i,
  input  fetch_pkg::loop_cnt_t hwlp_count_i,

  // word consumed by the aligner
  input  logic                 take_i,

  output imem_pkg::addr_t      pc_o,
  output logic                 prefetch_o,
  output imem_pkg::addr_t      prefetch_addr_o,
  output logic                 branch_o,
  output imem_pkg::addr_t      branch_addr_o,
  output logic                 hwlp_o,
  output imem_pkg::addr_t      hwlp_addr_o
);

  import imem_pkg::*;
  import fetch_pkg::*;

  seq_state_e state_q;
  addr_t      pc_q;
  addr_t      pc_d;

  addr_t      hwlp_start_q;
  addr_t      hwlp_end_q;
  loop_cnt_t  hwlp_cnt_q;

  line_addr_t next_line;
  logic       take_ok;
  logic       loop_jump;
  logic       line_end;

  // takes count only once running and never against a redirect
  assign take_ok = take_i && (state_q == RUN) && !branch_i;

  // jump back while more than one pass remains
  assign loop_jump = take_ok && (pc_q == hwlp_end_q) && (hwlp_cnt_q > loop_cnt_t'(1));

  // last word of the current line
  assign line_end = (pc_q[LINE_OFFS_W-1:2] == word_sel_t'(LINE_WORDS - 1));

  assign next_line = pc_q[ADDR_W-1:LINE_OFFS_W] + 1'b1;

  // next pc
  always_comb
  begin
    pc_d = pc_q;
    if (branch_i)
      pc_d = branch_addr_i;
    else if (loop_jump)
      pc_d = hwlp_start_q;
    else if (take_ok)
      pc_d = pc_q + addr_t'(4);
  end

  //////////////////////////////////////////////////////////////////////////
  // pc, state and request pulses
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= IDLE;
      pc_q       <= '0;
      branch_o   <= 1'b0;
      hwlp_o     <= 1'b0;
      prefetch_o <= 1'b0;
      hwlp_cnt_q <= '0;
    end
    else
    begin
      // first redirect starts fetching
      if (branch_i)
        state_q <= RUN;
      pc_q       <= pc_d;
      branch_o   <= branch_i;
      hwlp_o     <= loop_jump;
      // fall through past the line end needs the next line
      prefetch_o <= take_ok && !loop_jump && line_end;

      // remaining passes
      if (hwlp_set_i)
        hwlp_cnt_q <= hwlp_count_i;
      else if (loop_jump)
        hwlp_cnt_q <= hwlp_cnt_q - 1'b1;
    end
  end

  // addresses that go with the pulses
  always_ff @(posedge clk)
  begin
    if (branch_i)
      branch_addr_o <= branch_addr_i;
    if (loop_jump)
      hwlp_addr_o <= hwlp_start_q;
    if (take_ok)
      prefetch_addr_o <= {next_line, {LINE_OFFS_W{1'b0}}};
  end

  // loop bounds
  always_ff @(posedge clk)
  begin
    if (hwlp_set_i)
    begin
      hwlp_start_q <= hwlp_start_i;
      hwlp_end_q   <= hwlp_end_i;
    end
  end

  assign pc_o = pc_q;

endmodule

/* instr_aligner.sv */
////////////////////////////////////////////////////////////////////////////
// instruction aligner
// picks the word at pc out of the current line and holds it in a
// valid/ready output register towards the core
////////////////////////////////////////////////////////////////////////////

module instr_aligner (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 line_valid_i,
  input  imem_pkg::line_t      line_data_i,
  input  imem_pkg::line_addr_t line_addr_i,
  input  imem_pkg::addr_t      pc_i,
  input  logic                 branch_i,

  input  logic                 instr_ready_i,
  output logic                 take_o,
  output logic                 instr_valid_o,
  output fetch_pkg::instr_t    instr_data_o,
  output imem_pkg::addr_t      instr_addr_o
);

  import imem_pkg::*;
  import fetch_pkg::*;

  word_sel_t word_sel;
  instr_t    word;
  logic      hit;
  logic      load;
  logic      valid_q;

  assign word_sel = pc_i[LINE_OFFS_W-1:2];

  // word mux
  always_comb
  begin
    word = '0;
    for (int w = 0; w < LINE_WORDS; w++)
    begin
      if (word_sel == word_sel_t'(w))
        word = line_data_i[w*WORD_W +: WORD_W];
    end
  end

  // line holds the pc
  assign hit = line_valid_i && (line_addr_i == pc_i[ADDR_W-1:LINE_OFFS_W]);

  // free or draining this cycle, and no redirect
  assign load = hit && (!valid_q || instr_ready_i) && !branch_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (branch_i)
      // flush the old path
      valid_q <= 1'b0;
    else if (load)
      valid_q <= 1'b1;
    else if (instr_ready_i)
      valid_q <= 1'b0;
  end

  // held stable under back-pressure
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      instr_data_o <= word;
      instr_addr_o <= pc_i;
    end
  end

  assign take_o        = load;
  assign instr_valid_o = valid_q;

endmodule

/* fetch_top.sv */
////////////////////////////////////////////////////////////////////////////
// instruction fetch front end
// sequencer, L0 line buffer and aligner between core and memory
////////////////////////////////////////////////////////////////////////////

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // core side
  input  logic                 branch_i,
  input  imem_pkg::addr_t      branch_addr_i,
  output logic                 instr_valid_o,
  output fetch_pkg::instr_t    instr_data_o,
  output imem_pkg::addr_t      instr_addr_o,
  input  logic                 instr_ready_i,

  // loop configuration
  input  logic                 hwlp_set_i,
  input  imem_pkg::addr_t      hwlp_start_i,
  input  imem_pkg::addr_t      hwlp_end_i,
  input  fetch_pkg::loop_cnt_t hwlp_count_i,

  // instruction memory
  output logic                 imem_req_o,
  output imem_pkg::addr_t      imem_addr_o,
  input  logic                 imem_gnt_i,
  input  logic                 imem_rvalid_i,
  input  imem_pkg::line_t      imem_rdata_i,

  output logic                 busy_o
);

  import imem_pkg::*;

  // sequencer outputs
  addr_t      pc;
  logic       prefetch;
  addr_t      prefetch_addr;
  logic       seq_branch;
  addr_t      seq_branch_addr;
  logic       hwlp;
  addr_t      hwlp_addr;

  // L0 to aligner
  logic       line_valid;
  line_t      line_data;
  line_addr_t line_addr;

  logic       take;

  fetch_sequencer fetch_sequencer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .hwlp_set_i      (hwlp_set_i),
    .hwlp_start_i    (hwlp_start_i),
    .hwlp_end_i      (hwlp_end_i),
    .hwlp_count_i    (hwlp_count_i),
    .take_i          (take),
    .pc_o            (pc),
    .prefetch_o      (prefetch),
    .prefetch_addr_o (prefetch_addr),
    .branch_o        (seq_branch),
    .branch_addr_o   (seq_branch_addr),
    .hwlp_o          (hwlp),
    .hwlp_addr_o     (hwlp_addr)
  );

  l0_buffer l0_buffer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .prefetch_i      (prefetch),
    .prefetch_addr_i (prefetch_addr),
    .branch_i        (seq_branch),
    .branch_addr_i   (seq_branch_addr),
    .hwlp_i          (hwlp),
    .hwlp_addr_i     (hwlp_addr),
    .imem_req_o      (imem_req_o),
    .imem_addr_o     (imem_addr_o),
    .imem_gnt_i      (imem_gnt_i),
    .imem_rvalid_i   (imem_rvalid_i),
    .imem_rdata_i    (imem_rdata_i),
    .line_valid_o    (line_valid),
    .line_data_o     (line_data),
    .line_addr_o     (line_addr),
    .busy_o          (busy_o)
  );

  // aligner sees the core redirect directly for a same cycle flush
  instr_aligner instr_aligner_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .line_valid_i    (line_valid),
    .line_data_i     (line_data),
    .line_addr_i     (line_addr),
    .pc_i            (pc),
    .branch_i        (branch_i),
    .instr_ready_i   (instr_ready_i),
    .take_o          (take),
    .instr_valid_o   (instr_valid_o),
    .instr_data_o    (instr_data_o),
    .instr_addr_o    (instr_addr_o)
  );

endmodule

/* fetch_imem_model.sv */
////////////////////////////////////////////////////////////////////////////
// instruction memory responder for the fetch testbench
// answers req/gnt/rvalid with random grant and response delays and
// returns a line whose word at address a is a ^ A5A5_0000
////////////////////////////////////////////////////////////////////////////

module fetch_imem_model (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  imem_pkg::addr_t addr_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output imem_pkg::line_t rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import imem_pkg::*;

  localparam addr_t DATA_MASK = 32'hA5A5_0000;

  logic [31:0] rand_state;
  logic [31:0] rand_next;
  logic [1:0]  gnt_wait_q;
  logic [1:0]  rv_wait_q;
  logic        pending_q;
  addr_t       addr_q;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // word w of the line sits at base + 4w
  function automatic line_t line_at(input addr_t base);
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++)
      l[w*32 +: 32] = (base + addr_t'(4 * w)) ^ DATA_MASK;
    return l;
  endfunction

  assign rand_next = lcg_step(rand_state);

  // grant once the drawn wait has run out
  assign gnt_o = req_i && (gnt_wait_q == 2'd0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rand_state <= 32'd25836;
      gnt_wait_q <= '0;
      rv_wait_q  <= '0;
      pending_q  <= 1'b0;
      rvalid_o   <= 1'b0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      // response side, at least one cycle after the grant
      if (pending_q)
      begin
        if (rv_wait_q == 2'd0)
        begin
          rvalid_o  <= 1'b1;
          pending_q <= 1'b0;
        end
        else
          rv_wait_q <= rv_wait_q - 2'd1;
      end
      // accept, then draw delays for this response and the next grant
      if (gnt_o)
      begin
        rand_state <= rand_next;
        gnt_wait_q <= rand_next[29:28];
        rv_wait_q  <= rand_next[25:24];
        pending_q  <= 1'b1;
        addr_q     <= addr_i;
      end
      else if (req_i)
        gnt_wait_q <= gnt_wait_q - 2'd1;
    end
  end

  // data only meaningful with rvalid
  always_ff @(posedge clk)
  begin
    if (pending_q && (rv_wait_q == 2'd0))
      rdata_o <= line_at(addr_q);
  end

endmodule

/* fetch_checker.sv */
////////////////////////////////////////////////////////////////////////////
// memory protocol checks for the L0 buffer
// request address held while waiting for a grant, one outstanding
// request, no request in reset
////////////////////////////////////////////////////////////////////////////

module fetch_checker (
  input logic            clk,
  input logic            rst_n,
  input logic            branch_i,
  input logic            imem_req_i,
  input imem_pkg::addr_t imem_addr_i,
  input logic            imem_gnt_i,
  input logic            imem_rvalid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic outstanding_q;

  // granted but no rvalid yet
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      outstanding_q <= 1'b0;
    else if (imem_req_i && imem_gnt_i)
      outstanding_q <= 1'b1;
    else if (imem_rvalid_i)
      outstanding_q <= 1'b0;
  end

  // only a redirect may move a request that waits for its grant
  addr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (imem_req_i && !imem_gnt_i) |=> (branch_i || $stable(imem_addr_i)))
    else $error("imem address %h moved while waiting for grant", imem_addr_i);

  // a new grant is fine in the rvalid cycle of the previous one
  single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    (imem_req_i && imem_gnt_i) |-> (!outstanding_q || imem_rvalid_i))
    else $error("second imem request granted before rvalid");

  no_req_in_reset: assert property (@(posedge clk)
    !rst_n |-> !imem_req_i)
    else $error("imem request raised during reset");

endmodule

/* fetch_tb.sv */
////////////////////////////////////////////////////////////////////////////
// fetch front end testbench
// runs a table of scenarios through fetch_top against a random latency
// memory and checks every transfer against the pc and loop rules
////////////////////////////////////////////////////////////////////////////

module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import imem_pkg::*;
  import fetch_pkg::*;

  typedef struct packed {
    addr_t       start;
    logic [15:0] count;
    addr_t       lp_start;
    addr_t       lp_end;
    loop_cnt_t   lp_cnt;
    logic [7:0]  stall_pct;
    logic [15:0] br_idx;
    addr_t       br_target;
  } scenario_t;

  localparam int          NUM_TESTS = 7;
  localparam logic [15:0] NO_BRANCH = 16'hFFFF;
  localparam addr_t       DATA_MASK = 32'hA5A5_0000;

  // start, count, loop start/end/count, stall %, branch index, target
  localparam scenario_t SCENARIOS [NUM_TESTS] = '{
    '{32'h1000, 16'd20, 32'h0,    32'h0,    16'd0, 8'd0,  NO_BRANCH, 32'h0},
    '{32'h2008, 16'd16, 32'h0,    32'h0,    16'd0, 8'd0,  16'd6,     32'h3004},
    '{32'h4000, 16'd15, 32'h4004, 32'h4010, 16'd3, 8'd0,  NO_BRANCH, 32'h0},
    '{32'h5004, 16'd24, 32'h0,    32'h0,    16'd0, 8'd40, NO_BRANCH, 32'h0},
    '{32'h6000, 16'd14, 32'h6008, 32'h600C, 16'd2, 8'd30, 16'd9,     32'h7010},
    '{32'h800C, 16'd12, 32'h0,    32'h0,    16'd0, 8'd0,  16'd1,     32'h9000},
    '{32'hA000, 16'd10, 32'h0,    32'h0,    16'd0, 8'd20, 16'd0,     32'hB008}
  };

  string names [NUM_TESTS] = '{"seq_lines", "mid_branch", "hw_loop", "ready_stall",
                               "loop_branch_stall", "line_end_branch", "early_branch"};

  logic      clk;
  logic      rst_n;
  logic      branch_i;
  addr_t     branch_addr_i;
  logic      instr_valid_o;
  instr_t    instr_data_o;
  addr_t     instr_addr_o;
  logic      instr_ready_i;
  logic      hwlp_set_i;
  addr_t     hwlp_start_i;
  addr_t     hwlp_end_i;
  loop_cnt_t hwlp_count_i;
  logic      imem_req_o;
  addr_t     imem_addr_o;
  logic      imem_gnt_i;
  logic      imem_rvalid_i;
  line_t     imem_rdata_i;
  logic      busy_o;

  logic [31:0] rand_state;
  logic        mem_pending_q;
  int          errors;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;
  bit          verdict_done;

  fetch_top fetch_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid_o),
    .instr_data_o  (instr_data_o),
    .instr_addr_o  (instr_addr_o),
    .instr_ready_i (instr_ready_i),
    .hwlp_set_i    (hwlp_set_i),
    .hwlp_start_i  (hwlp_start_i),
    .hwlp_end_i    (hwlp_end_i),
    .hwlp_count_i  (hwlp_count_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_rdata_i  (imem_rdata_i),
    .busy_o        (busy_o)
  );

  fetch_imem_model imem_model_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (imem_req_o),
    .addr_i   (imem_addr_o),
    .gnt_o    (imem_gnt_i),
    .rvalid_o (imem_rvalid_i),
    .rdata_o  (imem_rdata_i)
  );

  bind l0_buffer fetch_checker fetch_checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .imem_req_i    (imem_req_o),
    .imem_addr_i   (imem_addr_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rvalid_i (imem_rvalid_i)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int total_instructions();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_TESTS; i++)
      sum += SCENARIOS[i].count;
    return sum;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // memory request granted and its response not back yet
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mem_pending_q <= 1'b0;
    else if (imem_req_o && imem_gnt_i)
      mem_pending_q <= 1'b1;
    else if (imem_rvalid_i)
      mem_pending_q <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////////
  // timeout
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    cycles      = 0;
    cycle_limit = total_instructions() * 12 + 200;
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    verdict_done = 1'b1;
    $display("SIMULATION FAILED");
    $finish;
  end

  // nothing may move before the first redirect
  task automatic check_reset_idle();
    int errs;
    errs = 0;
    repeat (10)
    begin
      @(negedge clk);
      if (imem_req_o || instr_valid_o || busy_o)
      begin
        $display("error reset_idle: expected req 0 valid 0 busy 0, actual req %b valid %b busy %b",
                 imem_req_o, instr_valid_o, busy_o);
        errs++;
      end
    end
    $display("test reset_idle: %0d errors", errs);
    errors += errs;
    if (errs != 0)
      tests_failed++;
  endtask

  task automatic run_scenario(input int idx);
    scenario_t sc;
    addr_t     exp_pc;
    loop_cnt_t exp_cnt;
    addr_t     hold_addr;
    instr_t    hold_data;
    logic      exp_busy;
    int        got;
    int        errs;
    bit        branched;
    bit        held;
    sc        = SCENARIOS[idx];
    exp_pc    = sc.start;
    exp_cnt   = sc.lp_cnt;
    got       = 0;
    errs      = 0;
    branched  = (sc.br_idx == NO_BRANCH);
    held      = 1'b0;
    hold_addr = '0;
    hold_data = '0;

    // redirect to the start and load the loop in the same cycle
    @(posedge clk);
    branch_i      <= 1'b1;
    branch_addr_i <= sc.start;
    hwlp_set_i    <= 1'b1;
    hwlp_start_i  <= sc.lp_start;
    hwlp_end_i    <= sc.lp_end;
    hwlp_count_i  <= sc.lp_cnt;
    instr_ready_i <= 1'b0;

    while (got < sc.count)
    begin
      @(posedge clk);
      hwlp_set_i <= 1'b0;
      if (!branched && (got == sc.br_idx))
      begin
        // no transfer in the redirect cycle
        branch_i      <= 1'b1;
        branch_addr_i <= sc.br_target;
        instr_ready_i <= 1'b0;
        branched      = 1'b1;
        exp_pc        = sc.br_target;
        held          = 1'b0;
      end
      else
      begin
        branch_i      <= 1'b0;
        rand_state    = lcg_step(rand_state);
        instr_ready_i <= ((rand_state >> 16) % 100) >= sc.stall_pct;
      end

      @(negedge clk);
      // busy while a memory request waits or is in flight
      exp_busy = imem_req_o || mem_pending_q;
      if (busy_o != exp_busy)
      begin
        $display("error %s: busy expected %b actual %b", names[idx], exp_busy, busy_o);
        errs++;
      end
      // word held from the last cycle must not move
      if (instr_valid_o && held && ((instr_addr_o != hold_addr) || (instr_data_o != hold_data)))
      begin
        $display("error %s: stalled word expected %h/%h actual %h/%h", names[idx],
                 hold_addr, hold_data, instr_addr_o, instr_data_o);
        errs++;
      end
      if (instr_valid_o && instr_ready_i)
      begin
        if (instr_addr_o != exp_pc)
        begin
          $display("error %s: transfer %0d address expected %h actual %h", names[idx],
                   got, exp_pc, instr_addr_o);
          errs++;
        end
        if (instr_data_o != (exp_pc ^ DATA_MASK))
        begin
          $display("error %s: transfer %0d data expected %h actual %h", names[idx],
                   got, exp_pc ^ DATA_MASK, instr_data_o);
          errs++;
        end
        got++;
        // loop back while passes remain, else step one word
        if ((exp_pc == sc.lp_end) && (exp_cnt > 1))
        begin
          exp_pc  = sc.lp_start;
          exp_cnt = exp_cnt - 1'b1;
        end
        else
          exp_pc = exp_pc + 32'd4;
      end
      held      = instr_valid_o && !instr_ready_i;
      hold_addr = instr_addr_o;
      hold_data = instr_data_o;
    end

    @(posedge clk);
    branch_i      <= 1'b0;
    instr_ready_i <= 1'b0;
    $display("test %s: %0d transfers, %0d errors", names[idx], got, errs);
    errors += errs;
    if (errs != 0)
      tests_failed++;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    hwlp_set_i    = 1'b0;
    hwlp_start_i  = '0;
    hwlp_end_i    = '0;
    hwlp_count_i  = '0;
    rand_state    = 32'd25836;
    errors        = 0;
    tests_failed  = 0;
    verdict_done  = 1'b0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    check_reset_idle();
    for (int i = 0; i < NUM_TESTS; i++)
      run_scenario(i);

    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS + 1, tests_failed, errors);
    verdict_done = 1'b1;
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // run ended without a verdict
  final
  begin
    if (!verdict_done)
      $display("SIMULATION FAILED");
  end

endmodule

/* sources.f */
imem_pkg.sv
fetch_pkg.sv
l0_buffer.sv
fetch_sequencer.sv
instr_aligner.sv
fetch_top.sv
fetch_imem_model.sv
fetch_checker.sv
fetch_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module fetch_tb -f sources.f -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
